// ==== src.f ====
source/lc3b_types.sv
source/lc3b_pipe.sv
source/buffer.sv
source/if_datapath.sv
source/id_datapath.sv
source/ex_datapath.sv
source/mem_datapath.sv
source/cpu_datapath.sv
testbench/cpu_tb.sv

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

    localparam int num_tests   = 5;
    localparam int test_cycles = 2000;

    logic                 clk;
    logic                 rst;
    logic                 resp_a  = 1'b0;
    lc3b_types::lc3b_word rdata_a = '0;
    logic                 read_a;
    logic                 write_a;
    logic [1:0]           wmask_a;
    lc3b_types::lc3b_word address_a;
    lc3b_types::lc3b_word wdata_a;
    logic                 resp_b  = 1'b0;
    lc3b_types::lc3b_word rdata_b = '0;
    logic                 read_b;
    logic                 write_b;
    logic [1:0]           wmask_b;
    lc3b_types::lc3b_word address_b;
    lc3b_types::lc3b_word wdata_b;

    lc3b_types::lc3b_word imem [32768];
    lc3b_types::lc3b_word dmem [32768];
    lc3b_types::lc3b_word st_addr [$];
    lc3b_types::lc3b_word st_data [$];
    lc3b_types::lc3b_word exp_addr [$];
    lc3b_types::lc3b_word exp_data [$];
    lc3b_types::lc3b_word fetch_log [$];
    lc3b_types::lc3b_word branch_pc;
    lc3b_types::lc3b_word branch_target;
    int                   prog_len     = 0;
    int                   wait_a       = 0;
    int                   wait_b       = 0;
    int                   delay_a      = 0;
    int                   delay_b      = 0;
    logic                 hold_a       = 1'b0;  // port a silent.
    logic                 random_delay = 1'b0;
    integer               seed         = 15901;

    cpu_datapath cpu_datapath_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(num_tests * test_cycles * 8);
        $display("watchdog timeout, the tests did not finish in time");
        abort_run();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int pick_delay();
        return random_delay ? $unsigned($random(seed)) % 4 : 0;
    endfunction

    always @(negedge clk) begin
        if (read_a && !hold_a && wait_a >= delay_a) begin
            check_bit("write_a", 1'b0, write_a);
            check_mask("wmask_a", 2'b11, wmask_a);
            check_word("wdata_a", 16'h0000, wdata_a);
            resp_a  <= 1'b1;
            rdata_a <= imem[address_a[15:1]];
            fetch_log.push_back(address_a);
            wait_a  = 0;
            delay_a = pick_delay();
        end else begin
            resp_a <= 1'b0;
            if (read_a) wait_a = wait_a + 1;
        end
    end

    // stores logged here, taken at the next rising edge.
    always @(negedge clk) begin
        if ((read_b || write_b) && wait_b >= delay_b) begin
            resp_b <= 1'b1;
            if (read_b) rdata_b <= dmem[address_b[15:1]];
            if (write_b) begin
                check_mask("wmask_b", 2'b11, wmask_b);
                dmem[address_b[15:1]] = wdata_b;
                st_addr.push_back(address_b);
                st_data.push_back(wdata_b);
            end
            wait_b  = 0;
            delay_b = pick_delay();
        end else begin
            resp_b <= 1'b0;
            if (read_b || write_b) wait_b = wait_b + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, lc3b_types::lc3b_word expected,
                              lc3b_types::lc3b_word actual);
        if (actual !== expected) begin
            $display("Fail time %0t: %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Fail time %0t: %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_mask(string name, logic [1:0] expected, logic [1:0] actual);
        if (actual !== expected) begin
            $display("Fail time %0t: %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic lc3b_types::lc3b_word encode(logic [3:0] op, logic [2:0] a,
                                                    logic [2:0] b, logic [5:0] low);
        return {op, a, b, low};
    endfunction

    function automatic lc3b_types::lc3b_word br_inst(logic [2:0] nzp, logic [8:0] off);
        return {4'b0000, nzp, off};
    endfunction

    function automatic lc3b_types::lc3b_word off6_bytes(logic [5:0] off);
        logic signed [15:0] wide;
        wide = $signed(off);
        return wide * 2;
    endfunction

    task automatic put_inst(lc3b_types::lc3b_word inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic put_spaced(lc3b_types::lc3b_word inst);
        put_inst(inst);
        repeat (3) put_inst(16'h0000);  // no forwarding.
    endtask

    task automatic expect_store(lc3b_types::lc3b_word addr, lc3b_types::lc3b_word data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic clear_program();
        for (int i = 0; i < 32768; i++) begin
            imem[i] = 16'h0000;
            dmem[i] = i * 16'h9e37 + 16'h1234;
        end
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic start_reset();
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
    endtask

    task automatic end_reset();
        repeat (15) @(negedge clk);
        rst = 1'b0;
        st_addr.delete();
        st_data.delete();
        fetch_log.delete();
    endtask

    task automatic run_and_compare();
        int cycles;
        cycles = 0;
        while (st_addr.size() < exp_addr.size() && cycles < test_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (st_addr.size() < exp_addr.size()) begin
            $display("only %0d of %0d expected stores reached port b", st_addr.size(),
                     exp_addr.size());
            abort_run();
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                check_word($sformatf("address_b store %0d", i), exp_addr[i], st_addr[i]);
                check_word($sformatf("wdata_b store %0d", i), exp_data[i], st_data[i]);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // programs and tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic load_arith();
        lc3b_types::lc3b_word va;
        lc3b_types::lc3b_word vb;
        va = 16'h7a5c;
        vb = 16'h0f3b;
        clear_program();
        dmem[8] = va;
        dmem[9] = vb;
        put_spaced(encode(lc3b_types::op_ldr, 3'd1, 3'd0, 6'd8));
        put_spaced(encode(lc3b_types::op_ldr, 3'd2, 3'd0, 6'd9));
        put_spaced(encode(lc3b_types::op_add, 3'd3, 3'd1, {3'b000, 3'd2}));
        put_spaced(encode(lc3b_types::op_add, 3'd4, 3'd1, {1'b1, 5'b11011}));  // -5.
        put_spaced(encode(lc3b_types::op_and, 3'd5, 3'd1, {3'b000, 3'd2}));
        put_spaced(encode(lc3b_types::op_and, 3'd6, 3'd1, {1'b1, 5'b01111}));
        put_spaced(encode(lc3b_types::op_not, 3'd7, 3'd1, 6'b111111));
        put_spaced(encode(lc3b_types::op_str, 3'd3, 3'd0, 6'd20));
        put_spaced(encode(lc3b_types::op_str, 3'd4, 3'd0, 6'd21));
        put_spaced(encode(lc3b_types::op_str, 3'd5, 3'd0, 6'd22));
        put_spaced(encode(lc3b_types::op_str, 3'd6, 3'd0, 6'd23));
        put_spaced(encode(lc3b_types::op_str, 3'd7, 3'd0, 6'd24));
        // r0 stays zero, so the byte address is twice the offset.
        expect_store(16'd40, va + vb);
        expect_store(16'd42, va - 16'd5);
        expect_store(16'd44, va & vb);
        expect_store(16'd46, va & 16'h000f);
        expect_store(16'd48, ~va);
    endtask

    task automatic load_branch();
        clear_program();
        dmem[11] = 16'h8001;  // negative, sets n.
        put_spaced(encode(lc3b_types::op_ldr, 3'd1, 3'd0, 6'd11));
        put_spaced(br_inst(3'b001, 9'd20));  // p only, falls through.
        put_spaced(encode(lc3b_types::op_str, 3'd1, 3'd0, 6'd25));
        branch_pc = prog_len * 2;
        put_inst(br_inst(3'b100, 9'd4));
        put_inst(encode(lc3b_types::op_str, 3'd1, 3'd0, 6'd26));  // wrong path.
        repeat (3) put_inst(16'h0000);
        put_spaced(encode(lc3b_types::op_str, 3'd1, 3'd0, 6'd27));
        branch_target = branch_pc + lc3b_types::word_bytes + (16'd4 << 1);
        expect_store(16'd50, 16'h8001);
        expect_store(16'd54, 16'h8001);
    endtask

    task automatic check_reset_outputs();
        check_bit("read_a", 1'b1, read_a);
        check_word("address_a", lc3b_types::pc_reset, address_a);
        check_bit("read_b", 1'b0, read_b);
        check_bit("write_b", 1'b0, write_b);
    endtask

    task automatic reset_state_test();
        hold_a = 1'b1;
        start_reset();
        clear_program();
        repeat (15) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_outputs();  // fetch still waiting on resp.
        hold_a = 1'b0;
    endtask

    task automatic arith_test();
        start_reset();
        load_arith();
        end_reset();
        run_and_compare();
    endtask

    task automatic addressing_test();
        lc3b_types::lc3b_word base;
        lc3b_types::lc3b_word pos_addr;
        lc3b_types::lc3b_word neg_addr;
        start_reset();
        clear_program();
        base     = 16'h0200;
        pos_addr = base + off6_bytes(6'd5);
        neg_addr = base + off6_bytes(6'b111001);
        dmem[10] = base;
        dmem[pos_addr[15:1]] = 16'hc0de;
        dmem[neg_addr[15:1]] = 16'h4b1d;
        put_spaced(encode(lc3b_types::op_ldr, 3'd1, 3'd0, 6'd10));
        put_spaced(encode(lc3b_types::op_ldr, 3'd2, 3'd1, 6'd5));
        put_spaced(encode(lc3b_types::op_ldr, 3'd3, 3'd1, 6'b111001));
        put_spaced(encode(lc3b_types::op_str, 3'd2, 3'd1, 6'b111101));
        put_spaced(encode(lc3b_types::op_str, 3'd3, 3'd1, 6'd12));
        expect_store(base + off6_bytes(6'b111101), 16'hc0de);
        expect_store(base + off6_bytes(6'd12), 16'h4b1d);
        end_reset();
        run_and_compare();
    endtask

    task automatic branch_test();
        int idx;
        start_reset();
        load_branch();
        end_reset();
        run_and_compare();
        // three slots behind the branch get fetched, then the target.
        idx = -1;
        for (int i = 0; i < fetch_log.size(); i++) begin
            if (idx < 0 && fetch_log[i] == branch_pc + 16'd6) idx = i;
        end
        if (idx < 0 || idx + 1 >= fetch_log.size()) begin
            $display("the fetch after the taken branch never showed up on port a");
            abort_run();
        end else begin
            check_word("address_a", branch_target, fetch_log[idx + 1]);
        end
    endtask

    // same store sequence as the zero-delay runs.
    task automatic backpressure_test();
        random_delay = 1'b1;
        start_reset();
        load_arith();
        end_reset();
        run_and_compare();
        start_reset();
        load_branch();
        end_reset();
        run_and_compare();
    endtask

    initial begin
        rst = 1'b1;
        reset_state_test();
        arith_test();
        addressing_test();
        branch_test();
        backpressure_test();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : cpu_tb

// ==== source/cpu_datapath.sv ====
`timescale 1ns/1ns

module cpu_datapath (
    input  logic                 clk,
    input  logic                 rst,

    // port a, fetch
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output logic                 read_a,
    output logic                 write_a,
    output logic [1:0]           wmask_a,
    output lc3b_types::lc3b_word address_a,
    output lc3b_types::lc3b_word wdata_a,

    // port b, load and store
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word rdata_b,
    output logic                 read_b,
    output logic                 write_b,
    output logic [1:0]           wmask_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b
);

    logic                 stall;
    logic                 flush;
    logic                 br_en;
    lc3b_types::lc3b_word br_target;

    lc3b_pipe::if_id_t  if_out;
    lc3b_pipe::if_id_t  if_id;
    lc3b_pipe::id_ex_t  id_out;
    lc3b_pipe::id_ex_t  id_ex;
    lc3b_pipe::ex_mem_t ex_out;
    lc3b_pipe::ex_mem_t ex_mem;
    lc3b_pipe::mem_wb_t mem_out;
    lc3b_pipe::mem_wb_t mem_wb;

    // fetch port never writes.
    assign write_a = 1'b0;
    assign wmask_a = 2'b11;
    assign wdata_a = '0;

    // any port still waiting freezes the whole pipe.
    assign stall = (read_a & ~resp_a) | ((read_b | write_b) & ~resp_b);
    assign flush = br_en & ~stall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages and buffers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    if_datapath if_stage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .br_en(br_en),
        .br_target(br_target),
        .read_a(read_a),
        .address_a(address_a),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .out(if_out)
    );

    buffer #(.payload_t(lc3b_pipe::if_id_t)) if_id_buf (
        .clk(clk), .rst(rst), .load(~stall), .flush(flush), .in(if_out), .out(if_id)
    );

    id_datapath id_stage (
        .clk(clk),
        .rst(rst),
        .in(if_id),
        .wb(mem_wb),
        .wb_valid(~stall),  // writeback retires on this edge.
        .out(id_out)
    );

    buffer #(.payload_t(lc3b_pipe::id_ex_t)) id_ex_buf (
        .clk(clk), .rst(rst), .load(~stall), .flush(flush), .in(id_out), .out(id_ex)
    );

    ex_datapath ex_stage (
        .in(id_ex),
        .out(ex_out)
    );

    buffer #(.payload_t(lc3b_pipe::ex_mem_t)) ex_mem_buf (
        .clk(clk), .rst(rst), .load(~stall), .flush(flush), .in(ex_out), .out(ex_mem)
    );

    mem_datapath mem_stage (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .in(ex_mem),
        .read_b(read_b),
        .write_b(write_b),
        .wmask_b(wmask_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .br_en(br_en),
        .br_target(br_target),
        .out(mem_out)
    );

    // the branch itself moves on to writeback.
    buffer #(.payload_t(lc3b_pipe::mem_wb_t)) mem_wb_buf (
        .clk(clk), .rst(rst), .load(~stall), .flush(1'b0), .in(mem_out), .out(mem_wb)
    );

endmodule : cpu_datapath

// ==== source/mem_datapath.sv ====
`timescale 1ns/1ns

module mem_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  lc3b_pipe::ex_mem_t   in,
    output logic                 read_b,
    output logic                 write_b,
    output logic [1:0]           wmask_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b,
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word rdata_b,
    output logic                 br_en,
    output lc3b_types::lc3b_word br_target,
    output lc3b_pipe::mem_wb_t   out
);

    logic                 b_done;
    lc3b_types::lc3b_word held_rdata;
    lc3b_types::lc3b_word load_data;
    lc3b_types::lc3b_word wb_data;
    lc3b_types::lc3b_nzp  nzp;
    lc3b_types::lc3b_nzp  nzp_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port b
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign read_b    = in.ctrl.mem_read & ~b_done;
    assign write_b   = in.ctrl.mem_write & ~b_done;
    assign wmask_b   = 2'b11;  // word access only.
    assign address_b = in.alu;
    assign wdata_b   = in.src2_data;

    // access served while port a still busy.
    always_ff @(posedge clk) begin
        if (rst || !stall) begin
            b_done <= 1'b0;
        end else if ((read_b || write_b) && resp_b) begin
            b_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_b && resp_b) held_rdata <= rdata_b;
    end

    assign load_data = b_done ? held_rdata : rdata_b;
    assign wb_data   = in.ctrl.mem_read ? load_data : in.alu;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // condition codes, branch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (wb_data[15])        nzp_next = 3'b100;
        else if (wb_data == '0) nzp_next = 3'b010;
        else                    nzp_next = 3'b001;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nzp <= 3'b010;
        end else if (in.ctrl.set_cc && !stall) begin
            nzp <= nzp_next;
        end
    end

    assign br_en     = in.ctrl.is_br & |(in.dest & nzp);
    assign br_target = in.br_target;

    always_comb begin
        out.ctrl = in.ctrl;
        out.dest = in.dest;
        out.data = wb_data;
    end

    rw_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(read_b && write_b)
    );

endmodule : mem_datapath

// ==== source/ex_datapath.sv ====
`timescale 1ns/1ns

module ex_datapath (
    input  lc3b_pipe::id_ex_t  in,
    output lc3b_pipe::ex_mem_t out
);

    lc3b_types::lc3b_word imm5;
    lc3b_types::lc3b_word offset6;
    lc3b_types::lc3b_word offset9;
    lc3b_types::lc3b_word opb;
    lc3b_types::lc3b_word alu_result;

    // offsets already in bytes.
    assign imm5    = {{11{in.instruction[4]}}, in.instruction[4:0]};
    assign offset6 = {{9{in.instruction[5]}}, in.instruction[5:0], 1'b0};
    assign offset9 = {{6{in.instruction[8]}}, in.instruction[8:0], 1'b0};
    assign opb     = in.ctrl.imm_sel ? imm5 : in.src2_data;

    always_comb begin
        if (in.ctrl.mem_read || in.ctrl.mem_write) begin
            alu_result = in.src1_data + offset6;  // base + offset.
        end else begin
            case (in.ctrl.alu_op)
                lc3b_pipe::alu_and: alu_result = in.src1_data & opb;
                lc3b_pipe::alu_not: alu_result = ~in.src1_data;
                default:            alu_result = in.src1_data + opb;
            endcase
        end
    end

    always_comb begin
        out.ctrl      = in.ctrl;
        out.dest      = in.dest;
        out.alu       = alu_result;
        out.br_target = in.pc + offset9;  // branch adder beside the alu.
        out.src2_data = in.src2_data;
    end

endmodule : ex_datapath

// ==== source/id_datapath.sv ====
`timescale 1ns/1ns

module id_datapath (
    input  logic              clk,
    input  logic              rst,
    input  lc3b_pipe::if_id_t in,
    input  lc3b_pipe::mem_wb_t wb,
    input  logic              wb_valid,
    output lc3b_pipe::id_ex_t out
);

    lc3b_pipe::lc3b_control_word ctrl;
    lc3b_types::lc3b_word        regfile [8];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl = '0;
        case (in.instruction[15:12])
            lc3b_types::op_add: begin
                ctrl.opcode       = lc3b_types::op_add;
                ctrl.alu_op       = lc3b_pipe::alu_add;
                ctrl.imm_sel      = in.instruction[5];
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            lc3b_types::op_and: begin
                ctrl.opcode       = lc3b_types::op_and;
                ctrl.alu_op       = lc3b_pipe::alu_and;
                ctrl.imm_sel      = in.instruction[5];
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            lc3b_types::op_not: begin
                ctrl.opcode       = lc3b_types::op_not;
                ctrl.alu_op       = lc3b_pipe::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            lc3b_types::op_ldr: begin
                ctrl.opcode       = lc3b_types::op_ldr;
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.set_cc       = 1'b1;
            end
            lc3b_types::op_str: begin
                ctrl.opcode    = lc3b_types::op_str;
                ctrl.mem_write = 1'b1;
            end
            lc3b_types::op_br: begin
                ctrl.opcode = lc3b_types::op_br;
                ctrl.is_br  = 1'b1;
            end
            default: ctrl = '0;  // unsupported, runs as a bubble.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // written at the end of writeback.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regfile[i] <= '0;
            end
        end else if (wb_valid && wb.ctrl.load_regfile) begin
            regfile[wb.dest] <= wb.data;
        end
    end

    always_comb begin
        out.ctrl        = ctrl;
        out.pc          = in.pc;
        out.instruction = in.instruction;
        out.dest        = in.dest;
        out.src1_data   = regfile[in.src1];
        out.src2_data   = regfile[in.src2];
    end

endmodule : id_datapath

// ==== source/if_datapath.sv ====
`timescale 1ns/1ns

module if_datapath (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 br_en,
    input  lc3b_types::lc3b_word br_target,
    output logic                 read_a,
    output lc3b_types::lc3b_word address_a,
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output lc3b_pipe::if_id_t    out
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;
    lc3b_types::lc3b_word held_inst;
    lc3b_types::lc3b_word inst;
    logic                 a_done;

    assign address_a = pc;
    assign read_a    = ~a_done;  // no new request once served.
    assign pc_plus2  = pc + lc3b_types::word_bytes;
    assign inst      = a_done ? held_inst : rdata_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= lc3b_types::pc_reset;
        end else if (!stall) begin
            pc <= br_en ? br_target : pc_plus2;
        end
    end

    // fetch served while port b still busy.
    always_ff @(posedge clk) begin
        if (rst || !stall) begin
            a_done <= 1'b0;
        end else if (read_a && resp_a) begin
            a_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_a && resp_a) held_inst <= rdata_a;
    end

    always_comb begin
        out.pc          = pc_plus2;
        out.instruction = inst;
        out.src1        = inst[8:6];
        out.dest        = inst[11:9];
        // str reads its source through src2.
        out.src2 = (inst[15:12] == lc3b_types::op_str) ? inst[11:9] : inst[2:0];
    end

    addr_a_held: assert property (
        @(posedge clk) disable iff (rst) (read_a && !resp_a) |=> $stable(address_a)
    );

endmodule : if_datapath

// ==== source/buffer.sv ====
`timescale 1ns/1ns

module buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  logic     flush,
    input  payload_t in,
    output payload_t out
);

    // flush drops a bubble in place of the stage.
    always_ff @(posedge clk) begin
        if (rst || (flush && load)) begin
            out <= '0;
        end else if (load) begin
            out <= in;
        end
    end

    // a flush during a freeze would be lost.
    flush_needs_load: assert property (
        @(posedge clk) disable iff (rst) flush |-> load
    );

endmodule : buffer

// ==== source/lc3b_pipe.sv ====
package lc3b_pipe;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_and = 2'b01,
        alu_not = 2'b10
    } lc3b_aluop;

    // all zero is a bubble.
    typedef struct packed {
        lc3b_types::lc3b_opcode opcode;
        lc3b_aluop              alu_op;
        logic                   imm_sel;
        logic                   load_regfile;
        logic                   mem_read;
        logic                   mem_write;
        logic                   set_cc;
        logic                   is_br;
    } lc3b_control_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        lc3b_types::lc3b_word pc;           // already pc+2.
        lc3b_types::lc3b_word instruction;
        lc3b_types::lc3b_reg  src1;
        lc3b_types::lc3b_reg  src2;
        lc3b_types::lc3b_reg  dest;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word instruction;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word src1_data;
        lc3b_types::lc3b_word src2_data;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_reg  dest;         // nzp mask for br.
        lc3b_types::lc3b_word alu;
        lc3b_types::lc3b_word br_target;
        lc3b_types::lc3b_word src2_data;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word data;
    } mem_wb_t;

endpackage : lc3b_pipe

// ==== source/lc3b_types.sv ====
package lc3b_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // basic words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // n, z, p from msb down.
    typedef logic [2:0]  lc3b_nzp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes in use
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        op_br  = 4'b0000,  // 0x0000 doubles as nop.
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam lc3b_word pc_reset   = 16'h0000;
    localparam lc3b_word word_bytes = 16'd2;

endpackage : lc3b_types
